//--- bench/execute_checker.sv
`timescale 1ns/10ps

module execute_checker (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,
    input  alu_pkg::alu_op_t            op,
    input  logic [alu_pkg::WORD_W-1:0]  src_a,
    input  logic [alu_pkg::WORD_W-1:0]  src_b,
    input  logic [4:0]                  sa,
    input  logic [alu_pkg::DWORD_W-1:0] hilo,
    input  logic                        ll_bit,
    input  logic                        mult_stall,
    input  logic                        div_stall,
    input  logic [alu_pkg::DWORD_W-1:0] result,
    input  logic                        overflow,
    input  logic                        trap,
    input  logic [alu_pkg::WORD_W-1:0]  adder_result,
    output int                          error_count,
    output int                          check_count
);
    import alu_pkg::*;

    function automatic logic [31:0] leading_count(input logic [31:0] w, input logic v);
        logic [31:0] n;
        logic        stop;
        n    = '0;
        stop = 1'b0;
        for (int i = 31; i >= 0; i--) begin
            if (w[i] != v) begin
                stop = 1'b1;
            end
            if (!stop) begin
                n = n + 1;
            end
        end
        return n;
    endfunction

    // packed as {result, overflow, trap, adder_result}
    function automatic logic [97:0] expected_outputs(
        input alu_op_t     o,
        input logic [31:0] a,
        input logic [31:0] b,
        input logic [4:0]  s,
        input logic [63:0] hl,
        input logic        ll
    );
        longint      la;
        longint      lb;
        longint      wide;
        logic [63:0] prod_s;
        logic [63:0] prod_u;
        logic [63:0] res;
        logic [31:0] sum;
        logic        ovf;
        logic        trp;
        la     = longint'($signed(a));
        lb     = longint'($signed(b));
        prod_s = la * lb;
        prod_u = {32'h0, a} * {32'h0, b};
        wide   = (o == OP_SUB) ? la - lb : la + lb;
        ovf    = (o == OP_ADD || o == OP_SUB) && (wide != longint'($signed(wide[31:0])));
        res    = '0;
        trp    = 1'b0;
        case (o)
            OP_SUB, OP_SUBU, OP_SLT, OP_SLTU, OP_TEQ, OP_TNE, OP_TGE, OP_TGEU,
            OP_TLT, OP_TLTU: sum = a - b;
            default:         sum = a + b;
        endcase
        case (o)
            OP_AND:   res = a & b;
            OP_OR:    res = a | b;
            OP_NOR:   res = {32'h0, ~(a | b)};
            OP_XOR:   res = a ^ b;
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: res = sum;
            OP_SLT:   res = ($signed(a) < $signed(b));
            OP_SLTU:  res = (a < b);
            OP_SLLV:  res = {32'h0, b << a[4:0]};
            OP_SRLV:  res = b >> a[4:0];
            OP_SRAV:  res = {32'h0, $signed(b) >>> a[4:0]};
            OP_SLL:   res = {32'h0, b << s};
            OP_SRL:   res = b >> s;
            OP_SRA:   res = {32'h0, $signed(b) >>> s};
            OP_LUI:   res = {32'h0, b[15:0], 16'h0};
            OP_CLO:   res = leading_count(a, 1'b1);
            OP_CLZ:   res = leading_count(a, 1'b0);
            OP_SC:    res = ll;
            OP_PASS:  res = a;
            OP_MTHI:  res = {a, hl[31:0]};
            OP_MTLO:  res = {hl[63:32], a};
            OP_TEQ:   trp = (a == b);
            OP_TNE:   trp = (a != b);
            OP_TGE:   trp = ($signed(a) >= $signed(b));
            OP_TGEU:  trp = (a >= b);
            OP_TLT:   trp = ($signed(a) < $signed(b));
            OP_TLTU:  trp = (a < b);
            OP_MULT:  res = prod_s;
            OP_MULTU: res = prod_u;
            OP_MADD:  res = hl + prod_s;
            OP_MADDU: res = hl + prod_u;
            OP_MSUB:  res = hl - prod_s;
            OP_MSUBU: res = hl - prod_u;
            OP_DIV, OP_DIVU: begin
                if (b == '0) begin
                    res = {a, 32'hffffffff};  // hi keeps a, lo all ones
                end else if (o == OP_DIV) begin
                    res = {32'(la % lb), 32'(la / lb)};
                end else begin
                    res = {a % b, a / b};
                end
            end
            default:  res = '0;
        endcase
        return {res, ovf, trp, sum};
    endfunction

    always @(posedge clk) begin : compare
        logic [97:0] exp_out;
        if (rst) begin
            error_count = 0;
            check_count = 0;
        end else if (flush) begin
            if (mult_stall || div_stall) begin  // flush must drop both stalls at once
                error_count = error_count + 1;
                $display("ERROR at %0t: stall still high during flush, op %s", $time, op.name());
            end
        end else if (!mult_stall && !div_stall) begin
            exp_out     = expected_outputs(op, src_a, src_b, sa, hilo, ll_bit);
            check_count = check_count + 1;
            if ({result, overflow, trap, adder_result} !== exp_out) begin
                error_count = error_count + 1;
                $display("ERROR at %0t: op %s got %h/%b/%b/%h expected %h/%b/%b/%h",
                         $time, op.name(), result, overflow, trap, adder_result,
                         exp_out[97:34], exp_out[33], exp_out[32], exp_out[31:0]);
            end
        end
    end

endmodule

//--- bench/tb_execute_unit.sv
`timescale 1ns/10ps

module tb_execute_unit;
    import alu_pkg::*;

    localparam int CLK_PERIOD = 8;
    // basic, shifts, clo/clz, traps, multiplies, mthi/mtlo, divides, flushes, reset
    localparam int TEST_COUNT = 13 * 4 + 2 + 36 + 8 + 36 + 36 + 4 + 12 + 2 + 1;

    logic               clk;
    logic               rst;
    logic               flush;
    logic               stall_m;
    alu_op_t            op;
    logic [WORD_W-1:0]  src_a;
    logic [WORD_W-1:0]  src_b;
    logic [4:0]         sa;
    logic [DWORD_W-1:0] hilo;
    logic               ll_bit;
    logic               mult_stall;
    logic               div_stall;
    logic [DWORD_W-1:0] result;
    logic               overflow;
    logic               trap;
    logic [WORD_W-1:0]  adder_result;
    int                 error_count;
    int                 check_count;
    integer             seed = 23;
    logic [31:0]        pa[6];
    logic [31:0]        pb[6];

    alu_op_t basic_ops[13] = '{OP_AND, OP_OR, OP_NOR, OP_XOR, OP_ADD, OP_ADDU, OP_SUB,
                               OP_SUBU, OP_SLT, OP_SLTU, OP_LUI, OP_PASS, OP_SC};
    alu_op_t shift_ops[6]  = '{OP_SLLV, OP_SRLV, OP_SRAV, OP_SLL, OP_SRL, OP_SRA};
    alu_op_t trap_ops[6]   = '{OP_TEQ, OP_TNE, OP_TGE, OP_TGEU, OP_TLT, OP_TLTU};
    alu_op_t mul_ops[6]    = '{OP_MULT, OP_MULTU, OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
    alu_op_t div_ops[2]    = '{OP_DIV, OP_DIVU};

    execute_unit i_execute_unit (.*);

    execute_checker i_execute_checker (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // holds the op until both stalls are low, then gives one edge to consume it
    task automatic apply_op(input alu_op_t o, input logic [31:0] a, input logic [31:0] b,
                            input logic [31:0] s, input int hold);
        logic [31:0] r;
        r       = $random(seed);
        op      = o;
        src_a   = a;
        src_b   = b;
        sa      = s[4:0];
        ll_bit  = r[0];
        hilo    = {$random(seed), r};
        stall_m = (hold > 0);  // memory stage back-pressure
        do begin
            @(negedge clk);
        end while (mult_stall || div_stall);
        repeat (hold) @(negedge clk);
        stall_m = 1'b0;
        @(negedge clk);
    endtask

    task automatic flush_and_reissue(input alu_op_t o, input logic [31:0] a,
                                     input logic [31:0] b);
        op    = o;
        src_a = a;
        src_b = b;
        repeat (5) @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;  // op still held so the unit restarts
        do begin
            @(negedge clk);
        end while (mult_stall || div_stall);
        @(negedge clk);
    endtask

    initial begin : stimulus
        logic [31:0] w;
        logic [31:0] v;
        logic [4:0]  amt;
        rst     = 1'b1;
        flush   = 1'b0;
        stall_m = 1'b0;
        op      = OP_AND;
        src_a   = '0;
        src_b   = '0;
        sa      = '0;
        hilo    = '0;
        ll_bit  = 1'b0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        foreach (basic_ops[i]) begin
            repeat (4) apply_op(basic_ops[i], $random(seed), $random(seed), 0, 0);
        end
        apply_op(OP_ADD, 32'h7fffffff, 32'd1, 0, 0);
        apply_op(OP_SUB, 32'h80000000, 32'd1, 0, 0);
        foreach (shift_ops[i]) begin
            for (int k = 0; k < 6; k++) begin
                w   = $random(seed);
                v   = $random(seed);
                amt = (k < 2) ? 5'd0 : (k < 4) ? 5'd31 : v[4:0];
                apply_op(shift_ops[i], {v[31:5], amt}, {k[0], w[30:0]}, {27'd0, amt}, 0);
            end
        end
        for (int k = 0; k < 4; k++) begin
            w = $random(seed);
            v = w >> w[4:0];
            w = (k == 0) ? 32'h0 : (k == 1) ? 32'hffffffff : (k == 2) ? v : ~v;
            apply_op(OP_CLO, w, 0, 0, 0);
            apply_op(OP_CLZ, w, 0, 0, 0);
        end
        w  = $random(seed);
        pa = '{w, 32'd1, 32'd2, 32'h80000000, 32'd5, 32'hffffffff};
        pb = '{w, 32'd2, 32'd1, 32'd5, 32'h80000000, 32'd0};
        foreach (trap_ops[i]) begin
            for (int k = 0; k < 6; k++) apply_op(trap_ops[i], pa[k], pb[k], 0, 0);
        end
        foreach (mul_ops[i]) begin
            pa = '{32'h80000000, 32'hffffffff, 32'h7fffffff, 32'd0,
                   $random(seed), $random(seed)};
            pb = '{32'h80000000, 32'd1, 32'h80000000, $random(seed),
                   $random(seed), $random(seed)};
            for (int k = 0; k < 6; k++) apply_op(mul_ops[i], pa[k], pb[k], 0, 0);
        end
        repeat (2) begin
            apply_op(OP_MTHI, $random(seed), 0, 0, 0);
            apply_op(OP_MTLO, $random(seed), 0, 0, 0);
        end
        foreach (div_ops[i]) begin
            pa = '{$random(seed), 32'hfffffff3, 32'd100, 32'hffffff9c, 32'h80000000,
                   $random(seed)};
            pb = '{$random(seed), 32'd4, 32'hfffffff9, 32'hfffffff9, 32'hffffffff, 32'd0};
            for (int k = 0; k < 6; k++) begin
                w = $random(seed);
                apply_op(div_ops[i], pa[k], pb[k], 0, 1 + int'(w[2:0]));
            end
        end
        flush_and_reissue(OP_MULT, $random(seed), $random(seed));
        flush_and_reissue(OP_DIVU, $random(seed), $random(seed));
        @(negedge clk);
        $display("checks: %0d  errors: %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(TEST_COUNT * (DIV_CYCLES + 10) * CLK_PERIOD);
        $display("timeout: the stimulus did not finish in time, a stall never dropped");
        $display("Verification failed");
        $finish;
    end

endmodule

//--- list.f
source/alu_pkg.sv
source/muldiv_if.sv
source/int_alu.sv
source/seq_multiplier.sv
source/radix2_divider.sv
source/execute_unit.sv
bench/execute_checker.sv
bench/tb_execute_unit.sv

//--- source/alu_pkg.sv
package alu_pkg;

    localparam int WORD_W      = 32;
    localparam int DWORD_W     = 64;
    localparam int MULT_CYCLES = 32;
    localparam int DIV_CYCLES  = 32;

    typedef enum logic [5:0] {
        OP_AND   = 6'h00,
        OP_OR    = 6'h01,
        OP_NOR   = 6'h02,
        OP_XOR   = 6'h03,
        OP_ADD   = 6'h04,
        OP_ADDU  = 6'h05,
        OP_SUB   = 6'h06,
        OP_SUBU  = 6'h07,
        OP_SLT   = 6'h08,
        OP_SLTU  = 6'h09,
        OP_SLLV  = 6'h0a,  // shift by src_a
        OP_SRLV  = 6'h0b,
        OP_SRAV  = 6'h0c,
        OP_SLL   = 6'h0d,  // shift by sa
        OP_SRL   = 6'h0e,
        OP_SRA   = 6'h0f,
        OP_LUI   = 6'h10,
        OP_CLO   = 6'h11,
        OP_CLZ   = 6'h12,
        OP_SC    = 6'h13,
        OP_PASS  = 6'h14,
        OP_MTHI  = 6'h15,
        OP_MTLO  = 6'h16,
        OP_TEQ   = 6'h18,
        OP_TNE   = 6'h19,
        OP_TGE   = 6'h1a,
        OP_TGEU  = 6'h1b,
        OP_TLT   = 6'h1c,
        OP_TLTU  = 6'h1d,
        OP_MULT  = 6'h20,
        OP_MULTU = 6'h21,
        OP_MADD  = 6'h22,
        OP_MADDU = 6'h23,
        OP_MSUB  = 6'h24,
        OP_MSUBU = 6'h25,
        OP_DIV   = 6'h28,
        OP_DIVU  = 6'h29
    } alu_op_t;

endpackage

//--- source/execute_unit.sv
`timescale 1ns/10ps

module execute_unit (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        flush,
    input  logic                        stall_m,
    input  alu_pkg::alu_op_t            op,
    input  logic [alu_pkg::WORD_W-1:0]  src_a,
    input  logic [alu_pkg::WORD_W-1:0]  src_b,
    input  logic [4:0]                  sa,
    input  logic [alu_pkg::DWORD_W-1:0] hilo,
    input  logic                        ll_bit,
    output logic                        mult_stall,
    output logic                        div_stall,
    output logic [alu_pkg::DWORD_W-1:0] result,
    output logic                        overflow,
    output logic                        trap,
    output logic [alu_pkg::WORD_W-1:0]  adder_result
);
    import alu_pkg::*;

    logic              mult_class;
    logic              mult_plain;
    logic              is_madd;
    logic              is_msub;
    logic              div_class;
    logic              is_mthi;
    logic              is_mtlo;
    logic [WORD_W-1:0] alu_result;

    muldiv_if mul_bus ();
    muldiv_if div_bus ();

    assign mult_plain = (op == OP_MULT) || (op == OP_MULTU);
    assign is_madd    = (op == OP_MADD) || (op == OP_MADDU);
    assign is_msub    = (op == OP_MSUB) || (op == OP_MSUBU);
    assign mult_class = mult_plain | is_madd | is_msub;
    assign div_class  = (op == OP_DIV) || (op == OP_DIVU);
    assign is_mthi    = (op == OP_MTHI);
    assign is_mtlo    = (op == OP_MTLO);

    assign mul_bus.a       = src_a;
    assign mul_bus.b       = src_b;
    assign mul_bus.sign    = (op == OP_MULT) || (op == OP_MADD) || (op == OP_MSUB);
    assign mul_bus.req     = mult_class;
    assign mul_bus.consume = mul_bus.done;
    assign mul_bus.flush   = flush;

    assign div_bus.a       = src_a;
    assign div_bus.b       = src_b;
    assign div_bus.sign    = (op == OP_DIV);
    assign div_bus.req     = div_class;
    assign div_bus.consume = div_bus.done & ~stall_m;  // wait for the memory stage
    assign div_bus.flush   = flush;

    assign mult_stall = mult_class & ~mul_bus.done & ~flush;
    assign div_stall  = div_class & ~div_bus.done & ~flush;

    int_alu i_int_alu (
        .op           (op),
        .src_a        (src_a),
        .src_b        (src_b),
        .sa           (sa),
        .ll_bit       (ll_bit),
        .result       (alu_result),
        .adder_result (adder_result),
        .overflow     (overflow),
        .trap         (trap)
    );

    seq_multiplier i_seq_multiplier (
        .clk (clk),
        .rst (rst),
        .md  (mul_bus.unit)
    );

    radix2_divider i_radix2_divider (
        .clk (clk),
        .rst (rst),
        .md  (div_bus.unit)
    );

    always_comb begin
        if (div_class) begin
            result = div_bus.result;
        end else if (mult_plain) begin
            result = mul_bus.result;
        end else if (is_madd) begin
            result = hilo + mul_bus.result;
        end else if (is_msub) begin
            result = hilo - mul_bus.result;
        end else if (is_mthi) begin
            result = {src_a, hilo[WORD_W-1:0]};
        end else if (is_mtlo) begin
            result = {hilo[DWORD_W-1:WORD_W], src_a};
        end else begin
            result = {{WORD_W{1'b0}}, alu_result};
        end
    end

endmodule

//--- source/int_alu.sv
`timescale 1ns/10ps

module int_alu (
    input  alu_pkg::alu_op_t           op,
    input  logic [alu_pkg::WORD_W-1:0] src_a,
    input  logic [alu_pkg::WORD_W-1:0] src_b,
    input  logic [4:0]                 sa,
    input  logic                       ll_bit,
    output logic [alu_pkg::WORD_W-1:0] result,
    output logic [alu_pkg::WORD_W-1:0] adder_result,
    output logic                       overflow,
    output logic                       trap
);
    import alu_pkg::*;

    logic is_and, is_or, is_nor, is_xor;
    logic is_add, is_addu, is_sub, is_subu;
    logic is_slt, is_sltu;
    logic is_sllv, is_srlv, is_srav, is_sll, is_srl, is_sra;
    logic is_lui, is_clo, is_clz, is_sc, is_pass;
    logic is_teq, is_tne, is_tge, is_tgeu, is_tlt, is_tltu;
    logic is_trap;
    logic sub_like;

    logic [WORD_W-1:0] adder_b;
    logic              adder_cout;
    logic              adder_zero;
    logic              slt_bit;
    logic              sltu_bit;

    logic [4:0]        shamt;
    logic              sr_fill;
    logic [WORD_W-1:0] sl_res;
    logic [WORD_W:0]   sr_ext;

    logic [WORD_W-1:0] lead_src;
    logic [5:0]        lead_cnt;

    assign is_and  = (op == OP_AND);
    assign is_or   = (op == OP_OR);
    assign is_nor  = (op == OP_NOR);
    assign is_xor  = (op == OP_XOR);
    assign is_add  = (op == OP_ADD);
    assign is_addu = (op == OP_ADDU);
    assign is_sub  = (op == OP_SUB);
    assign is_subu = (op == OP_SUBU);
    assign is_slt  = (op == OP_SLT);
    assign is_sltu = (op == OP_SLTU);
    assign is_sllv = (op == OP_SLLV);
    assign is_srlv = (op == OP_SRLV);
    assign is_srav = (op == OP_SRAV);
    assign is_sll  = (op == OP_SLL);
    assign is_srl  = (op == OP_SRL);
    assign is_sra  = (op == OP_SRA);
    assign is_lui  = (op == OP_LUI);
    assign is_clo  = (op == OP_CLO);
    assign is_clz  = (op == OP_CLZ);
    assign is_sc   = (op == OP_SC);
    assign is_pass = (op == OP_PASS);
    assign is_teq  = (op == OP_TEQ);
    assign is_tne  = (op == OP_TNE);
    assign is_tge  = (op == OP_TGE);
    assign is_tgeu = (op == OP_TGEU);
    assign is_tlt  = (op == OP_TLT);
    assign is_tltu = (op == OP_TLTU);

    assign is_trap  = is_teq | is_tne | is_tge | is_tgeu | is_tlt | is_tltu;
    assign sub_like = is_sub | is_subu | is_slt | is_sltu | is_trap;

    // one adder does a - b as a + ~b + 1
    assign adder_b = src_b ^ {WORD_W{sub_like}};
    assign {adder_cout, adder_result} = {1'b0, src_a} + {1'b0, adder_b}
                                      + {{WORD_W{1'b0}}, sub_like};
    assign adder_zero = (adder_result == '0);

    assign slt_bit  = (src_a[WORD_W-1] & ~src_b[WORD_W-1])
                    | (~(src_a[WORD_W-1] ^ src_b[WORD_W-1]) & adder_result[WORD_W-1]);
    assign sltu_bit = ~adder_cout;  // no carry means borrow

    // same-sign inputs with a sum of the other sign
    assign overflow = (is_add | is_sub)
                    & (src_a[WORD_W-1] == adder_b[WORD_W-1])
                    & (adder_result[WORD_W-1] != src_a[WORD_W-1]);

    assign trap = (is_teq  &  adder_zero)
                | (is_tne  & ~adder_zero)
                | (is_tge  & ~slt_bit)
                | (is_tgeu & ~sltu_bit)
                | (is_tlt  &  slt_bit)
                | (is_tltu &  sltu_bit);

    assign shamt   = (is_sllv | is_srlv | is_srav) ? src_a[4:0] : sa;
    assign sr_fill = (is_srav | is_sra) & src_b[WORD_W-1];
    assign sl_res  = src_b << shamt;
    assign sr_ext  = $signed({sr_fill, src_b}) >>> shamt;

    assign lead_src = is_clo ? ~src_a : src_a;  // clo counts zeros of ~a

    always_comb begin
        lead_cnt = 6'd32;
        for (int i = 0; i < WORD_W; i++) begin
            if (lead_src[i]) begin
                lead_cnt = 6'(WORD_W - 1 - i);  // highest set bit wins
            end
        end
    end

    assign result = ({WORD_W{is_and}} & (src_a & src_b))
                  | ({WORD_W{is_or}}  & (src_a | src_b))
                  | ({WORD_W{is_nor}} & ~(src_a | src_b))
                  | ({WORD_W{is_xor}} & (src_a ^ src_b))
                  | ({WORD_W{is_add | is_addu | is_sub | is_subu}} & adder_result)
                  | ({WORD_W{is_slt}}  & {{(WORD_W-1){1'b0}}, slt_bit})
                  | ({WORD_W{is_sltu}} & {{(WORD_W-1){1'b0}}, sltu_bit})
                  | ({WORD_W{is_sllv | is_sll}} & sl_res)
                  | ({WORD_W{is_srlv | is_srav | is_srl | is_sra}} & sr_ext[WORD_W-1:0])
                  | ({WORD_W{is_lui}} & {src_b[15:0], 16'h0000})
                  | ({WORD_W{is_clo | is_clz}} & {{(WORD_W-6){1'b0}}, lead_cnt})
                  | ({WORD_W{is_sc}}   & {{(WORD_W-1){1'b0}}, ll_bit})
                  | ({WORD_W{is_pass}} & src_a);

endmodule

//--- source/muldiv_if.sv
`timescale 1ns/10ps

interface muldiv_if;
    import alu_pkg::*;

    logic [WORD_W-1:0]  a;
    logic [WORD_W-1:0]  b;
    logic               sign;
    logic               req;      // level held for the whole op
    logic               consume;  // pulse that frees the unit
    logic               flush;
    logic               done;
    logic [DWORD_W-1:0] result;

    modport client (
        output a, b, sign, req, consume, flush,
        input  done, result
    );

    modport unit (
        input  a, b, sign, req, consume, flush,
        output done, result
    );

endinterface

//--- source/radix2_divider.sv
`timescale 1ns/10ps

module radix2_divider (
    input logic    clk,
    input logic    rst,
    muldiv_if.unit md
);
    import alu_pkg::*;

    localparam int CNT_W = $clog2(DIV_CYCLES);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(DIV_CYCLES - 1);
    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_BUSY = 2'd1;
    localparam logic [1:0] S_DONE = 2'd2;

    logic [1:0]        state;
    logic [CNT_W-1:0]  cnt;
    logic              b_zero;
    logic [WORD_W-1:0] mag_a;
    logic [WORD_W-1:0] mag_b;
    logic [WORD_W-1:0] rem;
    logic [WORD_W-1:0] quo;      // dividend shifts out as quotient shifts in
    logic [WORD_W-1:0] divisor;
    logic [WORD_W:0]   shifted;
    logic [WORD_W:0]   trial;
    logic              neg_q;
    logic              neg_r;

    assign b_zero = (md.b == '0);

    // divide by zero keeps a unsigned so the remainder comes back as a
    assign mag_a = (md.sign && md.a[WORD_W-1] && !b_zero) ? -md.a : md.a;
    assign mag_b = (md.sign && md.b[WORD_W-1]) ? -md.b : md.b;

    assign shifted = {rem, quo[WORD_W-1]};
    assign trial   = shifted - {1'b0, divisor};

    always_ff @(posedge clk) begin
        if (rst || md.flush) begin
            state <= S_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (md.req) begin
                        state <= S_BUSY;
                        cnt   <= '0;
                    end
                end
                S_BUSY: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == LAST) begin
                        state <= S_DONE;
                    end
                end
                S_DONE: begin
                    if (md.consume) begin  // held while the memory stage stalls
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && md.req) begin
            rem     <= '0;
            quo     <= mag_a;
            divisor <= mag_b;
            neg_q   <= md.sign & (md.a[WORD_W-1] ^ md.b[WORD_W-1]) & ~b_zero;
            neg_r   <= md.sign & md.a[WORD_W-1] & ~b_zero;
        end else if (state == S_BUSY) begin
            if (!trial[WORD_W]) begin  // fits so keep the difference
                rem <= trial[WORD_W-1:0];
                quo <= {quo[WORD_W-2:0], 1'b1};
            end else begin
                rem <= shifted[WORD_W-1:0];
                quo <= {quo[WORD_W-2:0], 1'b0};
            end
        end
    end

    assign md.done   = (state == S_DONE);
    assign md.result = {neg_r ? -rem : rem, neg_q ? -quo : quo};  // hi = rem, lo = quo

endmodule

//--- source/seq_multiplier.sv
`timescale 1ns/10ps

module seq_multiplier (
    input logic    clk,
    input logic    rst,
    muldiv_if.unit md
);
    import alu_pkg::*;

    localparam int CNT_W = $clog2(MULT_CYCLES);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(MULT_CYCLES - 1);
    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_BUSY = 2'd1;
    localparam logic [1:0] S_DONE = 2'd2;

    logic [1:0]         state;
    logic [CNT_W-1:0]   cnt;
    logic [WORD_W-1:0]  mag_a;
    logic [WORD_W-1:0]  mag_b;
    logic [WORD_W-1:0]  mcand;
    logic [DWORD_W-1:0] prod;    // upper half accumulates, lower half holds multiplier
    logic [WORD_W:0]    partial;
    logic               negate;

    assign mag_a = (md.sign && md.a[WORD_W-1]) ? -md.a : md.a;
    assign mag_b = (md.sign && md.b[WORD_W-1]) ? -md.b : md.b;

    assign partial = {1'b0, prod[DWORD_W-1:WORD_W]} + (prod[0] ? {1'b0, mcand} : '0);

    always_ff @(posedge clk) begin
        if (rst || md.flush) begin
            state <= S_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (md.req) begin
                        state <= S_BUSY;
                        cnt   <= '0;
                    end
                end
                S_BUSY: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == LAST) begin
                        state <= S_DONE;
                    end
                end
                S_DONE: begin
                    if (md.consume) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && md.req) begin
            mcand  <= mag_a;
            prod   <= {{WORD_W{1'b0}}, mag_b};
            negate <= md.sign & (md.a[WORD_W-1] ^ md.b[WORD_W-1]);
        end else if (state == S_BUSY) begin
            prod <= {partial, prod[WORD_W-1:1]};  // add then shift right
        end
    end

    assign md.done   = (state == S_DONE);
    assign md.result = negate ? -prod : prod;

endmodule
